// ==== design/vdp_debug_pkg.sv ====
package vdp_debug_pkg;

	// ----------------------------------------------------------
	// VDP I/O port numbers
	// ----------------------------------------------------------
	typedef logic [1:0] vdp_port_t;

	// VRAM data port, not used by the init sequence
	localparam vdp_port_t port_vram     = 2'd0;
	// Control port for register writes
	localparam vdp_port_t port_ctrl     = 2'd1;
	// Palette data port, LSB then MSB
	localparam vdp_port_t port_palette  = 2'd2;
	// Indirect register port, not used by the init sequence
	localparam vdp_port_t port_indirect = 2'd3;

	// ----------------------------------------------------------
	// Init table
	// ----------------------------------------------------------
	// Six register writes plus 16 palette pairs
	localparam int INIT_STEPS = 38;

	typedef logic [5:0] step_t;
	typedef logic [3:0] pal_index_t;

	// Register write view
	typedef struct packed {
		logic       is_reg;
		logic       spare;
		logic [5:0] reg_num;
		logic [7:0] value;
	} reg_view_t;

	// Palette byte view
	typedef struct packed {
		logic       is_reg;
		logic [6:0] spare;
		logic [7:0] data;
	} pal_view_t;

	// One table word, decoded by bit 15
	typedef union packed {
		reg_view_t reg_view;
		pal_view_t pal_view;
	} init_entry_u;

endpackage

// ==== design/vdp_bus_if.sv ====
`timescale 1ns/1ps

// Port-write bus between the init sequencer and the VDP model
interface vdp_bus_if
	import vdp_debug_pkg::*;
();
	// Held high until ack is seen
	logic      req;
	// One-cycle pulse while req is high
	logic      ack;
	vdp_port_t address;
	logic [7:0] wdata;

	// Sequencer side
	modport master (
		output req,
		output address,
		output wdata,
		input  ack
	);

	// VDP side
	modport target (
		input  req,
		input  address,
		input  wdata,
		output ack
	);

endinterface

// ==== design/key_conditioner.sv ====
`timescale 1ns/1ps

module key_conditioner #(
	parameter int DEBOUNCE_CYCLES = 4
) (
	input  logic       clk,
	input  logic       n_reset,
	input  logic [1:0] keys,
	output logic       start,
	output logic       pause
);
	localparam int cnt_w = $clog2(DEBOUNCE_CYCLES + 1);

	logic [1:0] sync_a;
	logic [1:0] sync_b;
	logic [1:0] level;
	logic       level0_d;
	logic       start_q;

	// ----------------------------------------------------------
	// Two-flop synchronizer
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			sync_a <= '0;
			sync_b <= '0;
		end
		else
		begin
			sync_a <= keys;
			sync_b <= sync_a;
		end
	end

	// ----------------------------------------------------------
	// Debounce, one counter per key
	// ----------------------------------------------------------
	for (genvar i = 0; i < 2; i++)
	begin : g_debounce
		// Samples that differ from the current level
		logic [cnt_w-1:0] cnt;

		always_ff @(posedge clk)
		begin
			if (!n_reset)
			begin
				cnt      <= '0;
				level[i] <= 1'b0;
			end
			else if (sync_b[i] == level[i])
			begin
				// Bounce back, start over
				cnt <= '0;
			end
			else if (cnt == cnt_w'(DEBOUNCE_CYCLES - 1))
			begin
				level[i] <= sync_b[i];
				cnt      <= '0;
			end
			else
			begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Rising edge of key 0, registered
	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			level0_d <= 1'b0;
			start_q  <= 1'b0;
		end
		else
		begin
			level0_d <= level[0];
			start_q  <= level[0] & ~level0_d;
		end
	end

	assign start = start_q;
	// Pause follows the debounced level
	assign pause = level[1];

endmodule

// ==== design/init_table_rom.sv ====
`timescale 1ns/1ps

module init_table_rom
	import vdp_debug_pkg::*;
(
	input  step_t       step,
	output init_entry_u entry
);
	// Register write word
	function automatic init_entry_u reg_entry(input logic [5:0] num, input logic [7:0] value);
		init_entry_u e;
		e                  = '0;
		e.reg_view.is_reg  = 1'b1;
		e.reg_view.reg_num = num;
		e.reg_view.value   = value;
		return e;
	endfunction

	// Palette byte word
	function automatic init_entry_u pal_entry(input logic [7:0] data);
		init_entry_u e;
		e               = '0;
		e.pal_view.data = data;
		return e;
	endfunction

	always_comb
	begin
		entry = '0;
		if (step < step_t'(INIT_STEPS))
		begin
			case (step)
			// ----------------------------------------------------------
			// Text mode, 40 columns
			// ----------------------------------------------------------
			6'd0:  entry = reg_entry(6'd0, 8'h00);
			6'd1:  entry = reg_entry(6'd1, 8'h50);
			// Name table at 0x0000
			6'd2:  entry = reg_entry(6'd2, 8'h00);
			// Pattern generator at 0x0800
			6'd3:  entry = reg_entry(6'd4, 8'h01);
			// White text on blue
			6'd4:  entry = reg_entry(6'd7, 8'hF4);
			// Palette pointer to entry 0
			6'd5:  entry = reg_entry(6'd16, 8'h00);
			// ----------------------------------------------------------
			// Palette, LSB (red/blue) then MSB (green)
			// ----------------------------------------------------------
			6'd6:  entry = pal_entry(8'h00);
			6'd7:  entry = pal_entry(8'h00);
			6'd8:  entry = pal_entry(8'h00);
			6'd9:  entry = pal_entry(8'h00);
			6'd10: entry = pal_entry(8'h33);
			6'd11: entry = pal_entry(8'h05);
			6'd12: entry = pal_entry(8'h44);
			6'd13: entry = pal_entry(8'h06);
			6'd14: entry = pal_entry(8'h37);
			6'd15: entry = pal_entry(8'h02);
			6'd16: entry = pal_entry(8'h47);
			6'd17: entry = pal_entry(8'h03);
			6'd18: entry = pal_entry(8'h52);
			6'd19: entry = pal_entry(8'h03);
			6'd20: entry = pal_entry(8'h36);
			6'd21: entry = pal_entry(8'h05);
			6'd22: entry = pal_entry(8'h62);
			6'd23: entry = pal_entry(8'h03);
			6'd24: entry = pal_entry(8'h63);
			6'd25: entry = pal_entry(8'h04);
			6'd26: entry = pal_entry(8'h53);
			6'd27: entry = pal_entry(8'h06);
			6'd28: entry = pal_entry(8'h64);
			6'd29: entry = pal_entry(8'h06);
			6'd30: entry = pal_entry(8'h21);
			6'd31: entry = pal_entry(8'h04);
			6'd32: entry = pal_entry(8'h55);
			6'd33: entry = pal_entry(8'h03);
			6'd34: entry = pal_entry(8'h55);
			6'd35: entry = pal_entry(8'h05);
			// White
			6'd36: entry = pal_entry(8'h77);
			6'd37: entry = pal_entry(8'h07);
			default: entry = '0;
			endcase
		end
	end

endmodule

// ==== design/init_sequencer.sv ====
`timescale 1ns/1ps

module init_sequencer
	import vdp_debug_pkg::*;
(
	input  logic        clk,
	input  logic        n_reset,
	input  logic        start,
	input  logic        pause,
	vdp_bus_if.master   bus,
	output logic        busy,
	output logic        done,
	output step_t       step,
	input  init_entry_u entry
);
	// FSM states
	localparam logic [2:0] st_idle     = 3'd0;
	localparam logic [2:0] st_fetch    = 3'd1;
	localparam logic [2:0] st_data     = 3'd2;
	localparam logic [2:0] st_data_ack = 3'd3;
	localparam logic [2:0] st_reg      = 3'd4;
	localparam logic [2:0] st_reg_ack  = 3'd5;
	localparam logic [2:0] st_adv      = 3'd6;

	logic [2:0]  state_q;
	step_t       step_q;
	init_entry_u entry_q;
	logic        busy_q;
	logic        done_q;
	logic        launch_data;
	logic        launch_reg;

	// New writes only start when not paused
	assign launch_data = (state_q == st_data) && !pause;
	assign launch_reg  = (state_q == st_reg) && !pause;

	// ----------------------------------------------------------
	// Control FSM
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			state_q <= st_idle;
			step_q  <= '0;
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
			bus.req <= 1'b0;
		end
		else
		begin
			case (state_q)
			st_idle:
				if (start)
				begin
					// Also the restart path after done
					step_q  <= '0;
					busy_q  <= 1'b1;
					done_q  <= 1'b0;
					state_q <= st_fetch;
				end
			st_fetch:
				state_q <= st_data;
			st_data:
				if (launch_data)
				begin
					bus.req <= 1'b1;
					state_q <= st_data_ack;
				end
			st_data_ack:
				if (bus.ack)
				begin
					bus.req <= 1'b0;
					state_q <= entry_q.reg_view.is_reg ? st_reg : st_adv;
				end
			st_reg:
				if (launch_reg)
				begin
					bus.req <= 1'b1;
					state_q <= st_reg_ack;
				end
			st_reg_ack:
				if (bus.ack)
				begin
					bus.req <= 1'b0;
					state_q <= st_adv;
				end
			st_adv:
				if (step_q == step_t'(INIT_STEPS - 1))
				begin
					busy_q  <= 1'b0;
					done_q  <= 1'b1;
					state_q <= st_idle;
				end
				else
				begin
					step_q  <= step_q + 1'b1;
					state_q <= st_fetch;
				end
			default:
				state_q <= st_idle;
			endcase
		end
	end

	// ----------------------------------------------------------
	// Entry and bus payload
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (state_q == st_fetch)
			entry_q <= entry;
		if (launch_data)
		begin
			bus.address <= entry_q.reg_view.is_reg ? port_ctrl : port_palette;
			bus.wdata   <= entry_q.reg_view.is_reg ? entry_q.reg_view.value
				: entry_q.pal_view.data;
		end
		else if (launch_reg)
		begin
			// Second control byte, 10 plus register number
			bus.address <= port_ctrl;
			bus.wdata   <= {2'b10, entry_q.reg_view.reg_num};
		end
	end

	assign step = step_q;
	assign busy = busy_q;
	assign done = done_q;

	// Request held with a stable payload until acknowledged
	a_req_stable: assert property (@(posedge clk) disable iff (!n_reset)
		bus.req && !bus.ack |=> bus.req && $stable(bus.address) && $stable(bus.wdata));

endmodule

// ==== design/vdp_port_target.sv ====
`timescale 1ns/1ps

module vdp_port_target
	import vdp_debug_pkg::*;
#(
	parameter int ACK_WAIT = 2
) (
	input  logic        clk,
	input  logic        n_reset,
	vdp_bus_if.target   bus,
	input  logic [5:0]  reg_sel,
	output logic [7:0]  reg_value,
	input  pal_index_t  pal_sel,
	output logic [15:0] pal_value
);
	localparam int wait_w = $clog2(ACK_WAIT + 2);

	logic [wait_w-1:0] wait_cnt;
	logic              take;
	logic              ctrl_second;
	logic [7:0]        ctrl_data;
	logic              pal_second;
	logic [7:0]        pal_lsb;
	pal_index_t        pal_idx;
	logic [7:0]        regs [64];
	logic [15:0]       palette [16];

	// Write accepted in the ack cycle
	assign take = bus.req && bus.ack;

	// ----------------------------------------------------------
	// Ack wait
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			wait_cnt <= '0;
			bus.ack  <= 1'b0;
		end
		else
		begin
			bus.ack <= 1'b0;
			if (bus.req && !bus.ack)
			begin
				if (wait_cnt == wait_w'(ACK_WAIT))
				begin
					bus.ack  <= 1'b1;
					wait_cnt <= '0;
				end
				else
				begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end
		end
	end

	// First bytes of a pair
	always_ff @(posedge clk)
	begin
		if (take && bus.address == port_ctrl && !ctrl_second)
			ctrl_data <= bus.wdata;
		if (take && bus.address == port_palette && !pal_second)
			pal_lsb <= bus.wdata;
	end

	// ----------------------------------------------------------
	// Register file and palette RAM
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			ctrl_second <= 1'b0;
			pal_second  <= 1'b0;
			pal_idx     <= '0;
			for (int i = 0; i < 64; i++)
				regs[i] <= '0;
			for (int i = 0; i < 16; i++)
				palette[i] <= '0;
		end
		else if (take)
		begin
			case (bus.address)
			port_ctrl:
				if (!ctrl_second)
				begin
					ctrl_second <= 1'b1;
				end
				else
				begin
					ctrl_second <= 1'b0;
					// Only 10 is a register write, 01 and 00 set up VRAM
					if (bus.wdata[7:6] == 2'b10)
					begin
						regs[bus.wdata[5:0]] <= ctrl_data;
						// R16 is the palette pointer
						if (bus.wdata[5:0] == 6'd16)
						begin
							pal_idx    <= ctrl_data[3:0];
							pal_second <= 1'b0;
						end
					end
				end
			port_palette:
				if (!pal_second)
				begin
					pal_second <= 1'b1;
				end
				else
				begin
					// MSB commits the pair and moves on
					palette[pal_idx] <= {bus.wdata, pal_lsb};
					pal_idx          <= pal_idx + 1'b1;
					pal_second       <= 1'b0;
				end
			port_vram, port_indirect:
				// No VRAM or indirect access in this model
				ctrl_second <= 1'b0;
			endcase
		end
	end

	// Readback
	assign reg_value = regs[reg_sel];
	assign pal_value = palette[pal_sel];

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!n_reset)
		bus.ack |-> bus.req);

endmodule

// ==== design/vdp_debug_top.sv ====
`timescale 1ns/1ps

module vdp_debug_top
	import vdp_debug_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 4,
	parameter int ACK_WAIT        = 2
) (
	input  logic        clk,
	input  logic        n_reset,
	input  logic [1:0]  keys,
	output logic        busy,
	output logic        done,
	input  logic [5:0]  reg_sel,
	output logic [7:0]  reg_value,
	input  pal_index_t  pal_sel,
	output logic [15:0] pal_value
);
	logic        start;
	logic        pause;
	step_t       step;
	init_entry_u entry;

	// Sequencer to VDP port writes
	vdp_bus_if bus_i ();

	key_conditioner #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) key_i (
		.clk     (clk),
		.n_reset (n_reset),
		.keys    (keys),
		.start   (start),
		.pause   (pause)
	);

	init_table_rom rom_i (
		.step  (step),
		.entry (entry)
	);

	init_sequencer seq_i (
		.clk     (clk),
		.n_reset (n_reset),
		.start   (start),
		.pause   (pause),
		.bus     (bus_i.master),
		.busy    (busy),
		.done    (done),
		.step    (step),
		.entry   (entry)
	);

	vdp_port_target #(
		.ACK_WAIT (ACK_WAIT)
	) target_i (
		.clk       (clk),
		.n_reset   (n_reset),
		.bus       (bus_i.target),
		.reg_sel   (reg_sel),
		.reg_value (reg_value),
		.pal_sel   (pal_sel),
		.pal_value (pal_value)
	);

endmodule

// ==== tb/tb_vdp_debug.sv ====
`timescale 1ns/1ps

module tb_vdp_debug
	import vdp_debug_pkg::*;
();

	logic        clk;
	logic        n_reset;
	logic [1:0]  keys;
	logic        busy;
	logic        done;
	logic [5:0]  reg_sel;
	logic [7:0]  reg_value;
	pal_index_t  pal_sel;
	logic [15:0] pal_value;

	logic [15:0] lfsr_q;
	int          errors;
	int          tests;
	int          failed_tests;

	vdp_debug_top dut_i (
		.clk       (clk),
		.n_reset   (n_reset),
		.keys      (keys),
		.busy      (busy),
		.done      (done),
		.reg_sel   (reg_sel),
		.reg_value (reg_value),
		.pal_sel   (pal_sel),
		.pal_value (pal_value)
	);

	// 20 ns clock
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------------------------------------
	// Expected init values
	// ------------------------------------------------------------
	// Text mode register set, others stay 0
	function automatic int expected_reg(input int num);
		case (num)
		1:       return 'h50;
		4:       return 'h01;
		7:       return 'hF4;
		default: return 0;
		endcase
	endfunction

	// MSB in the upper byte, LSB in the lower
	function automatic int expected_pal(input int idx);
		case (idx)
		2:       return 'h0533;
		3:       return 'h0644;
		4:       return 'h0237;
		5:       return 'h0347;
		6:       return 'h0352;
		7:       return 'h0536;
		8:       return 'h0362;
		9:       return 'h0463;
		10:      return 'h0653;
		11:      return 'h0664;
		12:      return 'h0421;
		13:      return 'h0355;
		14:      return 'h0555;
		15:      return 'h0777;
		default: return 0;
		endcase
	endfunction

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = next_lfsr(lfsr_q);
			value  = (value << 1) | int'(lfsr_q[0]);
		end
	endtask

	// ------------------------------------------------------------
	// Checks and waits
	// ------------------------------------------------------------
	task automatic check_equal(input string test, input string what, input int expected,
		input int actual);
		assert (actual == expected)
		else
		begin
			$display("FAILED %s: %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
			errors++;
		end
	endtask

	// Readback is combinational, sampled on the falling edge
	task automatic check_regs(input string test, input bit after_init);
		for (int i = 0; i < 64; i++)
		begin
			@(posedge clk);
			reg_sel <= 6'(i);
			@(negedge clk);
			check_equal(test, $sformatf("R%0d", i), after_init ? expected_reg(i) : 0,
				int'(reg_value));
		end
	endtask

	task automatic check_palette(input string test, input bit after_init);
		for (int i = 0; i < 16; i++)
		begin
			@(posedge clk);
			pal_sel <= pal_index_t'(i);
			@(negedge clk);
			check_equal(test, $sformatf("palette %0d", i), after_init ? expected_pal(i) : 0,
				int'(pal_value));
		end
	endtask

	task automatic wait_for_flag(input string test, input bit use_done, input bit level,
		input int limit);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < limit && !seen; n++)
		begin
			@(negedge clk);
			seen = ((use_done ? done : busy) == level);
		end
		if (!seen)
		begin
			$display("%s: %s did not go to %0d within %0d cycles", test,
				use_done ? "done" : "busy", level, limit);
			errors++;
		end
	endtask

	// busy and done must hold their levels
	task automatic check_steady(input string test, input int cycles, input bit busy_want,
		input bit done_want);
		for (int n = 0; n < cycles; n++)
		begin
			@(negedge clk);
			check_equal(test, "busy", busy_want, busy);
			check_equal(test, "done", done_want, done);
		end
	endtask

	// Drive a key for a number of cycles
	task automatic press_key(input int idx, input int cycles);
		@(posedge clk);
		keys[idx] <= 1'b1;
		repeat (cycles) @(posedge clk);
		keys[idx] <= 1'b0;
	endtask

	task automatic end_test(input string test, input int errors_before);
		tests++;
		if (errors == errors_before)
			$display("test %s: ok", test);
		else
		begin
			failed_tests++;
			$display("test %s: %0d errors", test, errors - errors_before);
		end
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial
	begin
		int mark;
		int len;
		lfsr_q       = 16'd33583;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		n_reset <= 1'b0;
		keys    <= 2'b00;
		reg_sel <= '0;
		pal_sel <= '0;
		repeat (2) @(posedge clk);
		n_reset <= 1'b1;

		// Idle after reset
		mark = errors;
		check_steady("reset", 1, 1'b0, 1'b0);
		check_regs("reset", 1'b0);
		check_palette("reset", 1'b0);
		check_steady("reset", 50, 1'b0, 1'b0);
		end_test("reset", mark);

		// Press held well past the debounce time
		mark = errors;
		take_bits(3, len);
		press_key(0, 8 + len);
		wait_for_flag("run", 1'b0, 1'b1, 50);
		wait_for_flag("run", 1'b1, 1'b1, 2000);
		check_regs("run", 1'b1);
		end_test("run", mark);

		mark = errors;
		check_palette("palette", 1'b1);
		end_test("palette", mark);

		// Pause partway through a run
		mark = errors;
		press_key(0, 10);
		wait_for_flag("pause", 1'b0, 1'b1, 50);
		@(posedge clk);
		keys[1] <= 1'b1;
		repeat (10) @(posedge clk);
		// Held longer than a full unpaused run takes
		check_steady("pause", 400, 1'b1, 1'b0);
		@(posedge clk);
		keys[1] <= 1'b0;
		wait_for_flag("pause", 1'b1, 1'b1, 2000);
		check_regs("pause", 1'b1);
		check_palette("pause", 1'b1);
		end_test("pause", mark);

		// Short glitch, then a key held through a whole run
		mark = errors;
		take_bits(2, len);
		press_key(0, (len % 3) + 1);
		check_steady("no restart", 30, 1'b0, 1'b1);
		@(posedge clk);
		keys[0] <= 1'b1;
		wait_for_flag("no restart", 1'b0, 1'b1, 50);
		wait_for_flag("no restart", 1'b1, 1'b1, 2000);
		check_steady("no restart", 50, 1'b0, 1'b1);
		@(posedge clk);
		keys[0] <= 1'b0;
		check_steady("no restart", 20, 1'b0, 1'b1);
		end_test("no restart", mark);

		// Fresh press after done
		mark = errors;
		take_bits(3, len);
		press_key(0, 8 + len);
		wait_for_flag("restart", 1'b1, 1'b0, 50);
		check_equal("restart", "busy", 1, busy);
		wait_for_flag("restart", 1'b1, 1'b1, 2000);
		check_regs("restart", 1'b1);
		check_palette("restart", 1'b1);
		end_test("restart", mark);

		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
design/vdp_debug_pkg.sv
design/vdp_bus_if.sv
design/key_conditioner.sv
design/init_table_rom.sv
design/init_sequencer.sv
design/vdp_port_target.sv
design/vdp_debug_top.sv
tb/tb_vdp_debug.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_vdp_debug -f build.f

out=$(./obj_dir/Vtb_vdp_debug)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1
